// File: common/mem_pipe_pkg.sv
/*
  shared widths, enums and structs for the memory pipeline.
  widths are fixed by the memory port: 64-bit lines, 4-bit tags.
  tag zero is reserved and means no transaction.
*/

package mem_pipe_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int addr_w     = 32;
    localparam int block_w    = 64;
    localparam int tag_w      = 4;
    localparam int line_bytes = 8;  // fetch step, one memory line

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        mem_none  = 2'h0,
        mem_load  = 2'h1,
        mem_store = 2'h2
    } mem_cmd_t;

    typedef enum logic [1:0] {
        size_byte   = 2'h0,
        size_half   = 2'h1,
        size_word   = 2'h2,
        size_double = 2'h3
    } mem_size_t;

    ////////////////////////////////////////
    // bundles
    ////////////////////////////////////////

    // operation as delivered by execute, also the ex_mem register
    typedef struct packed {
        logic                valid;
        mem_cmd_t            cmd;
        mem_size_t           size;
        logic [addr_w-1:0]   addr;
        logic [block_w-1:0]  data;   // store data, low aligned
    } mem_op_t;

    // processor to memory
    typedef struct packed {
        mem_cmd_t            cmd;
        mem_size_t           size;
        logic [addr_w-1:0]   addr;
        logic [block_w-1:0]  data;
    } mem_req_t;

    // memory to processor
    typedef struct packed {
        logic [tag_w-1:0]    transaction_tag;  // same cycle as request
        logic [tag_w-1:0]    data_tag;         // later, one cycle, zero when idle
        logic [block_w-1:0]  data;
    } mem_rsp_t;

    // one finished operation
    typedef struct packed {
        logic                valid;
        mem_cmd_t            cmd;
        logic [addr_w-1:0]   addr;
        logic [block_w-1:0]  data;
    } commit_t;

    // one fetched line
    typedef struct packed {
        logic                valid;
        logic [addr_w-1:0]   addr;
        logic [block_w-1:0]  data;
    } fetch_t;

endpackage

// File: verilog/fetch_unit.sv
/*
  sequential line fetch, one read outstanding at a time.
  no redirect: pc only steps forward by line_bytes.
*/

`timescale 1ns/1ps

module fetch_unit import mem_pipe_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic              fetch_grant,  // port free this cycle
    input  mem_rsp_t          mem2proc,
    output mem_req_t          fetch_req,
    output fetch_t            fetched,
    output logic [addr_w-1:0] pc
);

    logic             pending;   // read in flight
    logic [tag_w-1:0] pend_tag;  // tag of that read
    logic             line_back;

    // request only while idle, always a full line
    always_comb begin
        fetch_req.cmd  = pending ? mem_none : mem_load;
        fetch_req.size = size_double;
        fetch_req.addr = pc;
        fetch_req.data = '0;  // never stores
    end

    assign line_back = pending && (mem2proc.data_tag == pend_tag);

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            pc            <= '0;
            pending       <= 1'b0;
            pend_tag      <= '0;
            fetched.valid <= 1'b0;
        end else begin
            fetched.valid <= line_back;  // one cycle pulse
            if (line_back) begin
                pending <= 1'b0;
                pend_tag <= '0;
                pc      <= pc + addr_w'(line_bytes);  // next line
            end else if (!pending && fetch_grant) begin
                // memory tags every request in the same cycle
                pending  <= 1'b1;
                pend_tag <= mem2proc.transaction_tag;
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clock) begin
        if (line_back) begin
            fetched.addr <= pc;
            fetched.data <= mem2proc.data;
        end
    end

endmodule

// File: memory/mem_access.sv
/*
  memory stage datapath, purely combinational.
  load data is right aligned by the low address bits and zero extended.
  accesses are assumed not to cross a 64-bit line.
*/

`timescale 1ns/1ps

module mem_access import mem_pipe_pkg::*; (
    input  mem_op_t            ex_mem,
    input  logic [block_w-1:0] load_data,    // raw line from memory
    output mem_req_t           data_req,
    output commit_t            commit_next
);

    logic [5:0]         shift_bits;  // byte offset in bits
    logic [block_w-1:0] shifted;
    logic [block_w-1:0] mask;

    // keep only the low bytes of the access size
    function automatic logic [block_w-1:0] size_mask(input mem_size_t size);
        logic [block_w-1:0] m;
        case (size)
            size_byte:   m = block_w'(8'hff);
            size_half:   m = block_w'(16'hffff);
            size_word:   m = block_w'(32'hffff_ffff);
            default:     m = '1;  // double
        endcase
        return m;
    endfunction

    ////////////////////////////////////////
    // request to memory
    ////////////////////////////////////////

    always_comb begin
        data_req.cmd  = ex_mem.valid ? ex_mem.cmd : mem_none;  // bubble sends nothing
        data_req.size = ex_mem.size;
        data_req.addr = ex_mem.addr;
        data_req.data = ex_mem.data;
    end

    ////////////////////////////////////////
    // load extraction
    ////////////////////////////////////////

    assign shift_bits = {ex_mem.addr[2:0], 3'b000};
    assign shifted    = load_data >> shift_bits;
    assign mask       = size_mask(ex_mem.size);

    // commit candidate, taken by mem_wb when no stall
    always_comb begin
        commit_next.valid = ex_mem.valid;
        commit_next.cmd   = ex_mem.cmd;
        commit_next.addr  = ex_mem.addr;
        if (ex_mem.cmd == mem_load) begin
            commit_next.data = shifted & mask;     // zero extended
        end else begin
            commit_next.data = ex_mem.data & mask; // store, as written
        end
    end

endmodule

// File: memory/load_tracker.sv
/*
  load stall by transaction tag plus the shared port mux.
  a load is sent once, then the pipe stalls until its data tag returns.
  the data side owns the port while a load waits, so fetch is held off.
*/

`timescale 1ns/1ps

module load_tracker import mem_pipe_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  mem_op_t  ex_mem,
    input  mem_req_t data_req,
    input  mem_req_t fetch_req,
    input  mem_rsp_t mem2proc,
    output logic     stall,
    output logic     fetch_grant,
    output mem_req_t proc2mem
);

    logic             valid_load;  // load sits in ex_mem
    logic             new_load;    // its first cycle
    logic             tag_match;
    logic             load_wait_q; // load was already waiting last cycle
    logic [tag_w-1:0] out_tag;     // tag the load waits on
    mem_cmd_t         data_cmd_filt;

    ////////////////////////////////////////
    // stall
    ////////////////////////////////////////

    assign valid_load = ex_mem.valid && (ex_mem.cmd == mem_load);
    assign new_load   = valid_load && !load_wait_q;
    assign tag_match  = (out_tag == mem2proc.data_tag);
    assign stall      = new_load || (valid_load && !tag_match);

    // wait flag follows the stall so back to back loads each issue
    always_ff @(posedge clock) begin
        if (reset) begin
            load_wait_q <= 1'b0;
            out_tag     <= '0;
        end else begin
            load_wait_q <= stall;
            if (new_load) begin
                out_tag <= mem2proc.transaction_tag;
            end else if (tag_match) begin
                out_tag <= '0;  // back to no tag once the data is in
            end
        end
    end

    ////////////////////////////////////////
    // port arbitration
    ////////////////////////////////////////

    // repeat loads dropped and stores go straight through
    assign data_cmd_filt = (new_load || data_req.cmd == mem_store) ? data_req.cmd : mem_none;

    assign fetch_grant = (data_req.cmd == mem_none);  // data side first

    always_comb begin
        if (!fetch_grant) begin
            proc2mem.cmd  = data_cmd_filt;
            proc2mem.size = data_req.size;
            proc2mem.addr = data_req.addr;
            proc2mem.data = data_req.data;   // only meaningful on stores
        end else begin
            proc2mem.cmd  = fetch_req.cmd;
            proc2mem.size = fetch_req.size;  // full line for instructions
            proc2mem.addr = fetch_req.addr;
            proc2mem.data = fetch_req.data;
        end
    end

endmodule

// File: verilog/pipe_regs.sv
/*
  ex_mem and mem_wb stage registers.
  on stall ex_mem holds and mem_wb takes a bubble.
*/

`timescale 1ns/1ps

module pipe_regs import mem_pipe_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    stall,        // level, from load tracking
    input  mem_op_t op_in,        // from execute, held by source on stall
    input  commit_t commit_next,
    output mem_op_t ex_mem,
    output commit_t commit
);

    ////////////////////////////////////////
    // ex/mem
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            ex_mem <= '0;  // invalid, mem_none
        end else if (!stall) begin
            ex_mem <= op_in;
        end
    end

    ////////////////////////////////////////
    // mem/wb, drives commit
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            commit <= '0;
        end else if (stall) begin
            commit.valid <= 1'b0;  // bubble
        end else begin
            commit <= commit_next; // one cycle valid per op
        end
    end

endmodule

// File: verilog/mem_pipe_top.sv
/*
  memory side of the pipeline: fetch, stage registers, load tracking.
  ops enter at the execute boundary without handshake; stall is the only
  back-pressure and the source must hold op_in while it is high.
*/

`timescale 1ns/1ps

module mem_pipe_top import mem_pipe_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  mem_op_t           op_in,
    input  mem_rsp_t          mem2proc,
    output mem_req_t          proc2mem,
    output logic              stall,
    output commit_t           commit,
    output fetch_t            fetched,
    output logic [addr_w-1:0] pc
);

    mem_op_t  ex_mem;       // stage register contents
    mem_req_t data_req;     // unfiltered data request
    mem_req_t fetch_req;
    commit_t  commit_next;
    logic     fetch_grant;

    ////////////////////////////////////////
    // fetch
    ////////////////////////////////////////

    fetch_unit fetch_unit_0 (
        .clock       (clock),
        .reset       (reset),
        .fetch_grant (fetch_grant),
        .mem2proc    (mem2proc),
        .fetch_req   (fetch_req),
        .fetched     (fetched),
        .pc          (pc)
    );

    ////////////////////////////////////////
    // stage registers
    ////////////////////////////////////////

    pipe_regs pipe_regs_0 (
        .clock       (clock),
        .reset       (reset),
        .stall       (stall),
        .op_in       (op_in),
        .commit_next (commit_next),
        .ex_mem      (ex_mem),
        .commit      (commit)
    );

    ////////////////////////////////////////
    // memory stage
    ////////////////////////////////////////

    mem_access mem_access_0 (
        .ex_mem      (ex_mem),
        .load_data   (mem2proc.data),  // same bus as fetch data
        .data_req    (data_req),
        .commit_next (commit_next)
    );

    load_tracker load_tracker_0 (
        .clock       (clock),
        .reset       (reset),
        .ex_mem      (ex_mem),
        .data_req    (data_req),
        .fetch_req   (fetch_req),
        .mem2proc    (mem2proc),
        .stall       (stall),
        .fetch_grant (fetch_grant),
        .proc2mem    (proc2mem)
    );

endmodule

// File: test/tb_clock.sv
/*
  clock and reset for the testbench.
  40 ns period, reset held for 16 rising edges.
*/

`timescale 1ns/1ps

module tb_clock (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // release just after an edge like the rest of the stimulus
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clock);
        #2;
        reset = 1'b0;
    end

endmodule

// File: test/tb_mem_model.sv
/*
  tagged memory model of 256 lines of 64 bits, indexed by addr[10:3].
  tags run 1 to 15, load data comes back 1 to 6 cycles later, one per cycle.
  stores return nothing. shadow starts equal to mem and is kept by the testbench.
*/

`timescale 1ns/1ps

module tb_mem_model import mem_pipe_pkg::*; #(
    parameter int unsigned seed_init = 0
) (
    input  logic     clock,
    input  logic     reset,
    input  mem_req_t proc2mem,
    output mem_rsp_t mem2proc
);

    logic [block_w-1:0] mem    [256];
    logic [block_w-1:0] shadow [256];
    integer             seed;
    int                 cyc;
    int                 k;
    int                 pick;
    logic               found;
    logic [tag_w-1:0]   next_tag;
    logic [tag_w-1:0]   rsp_tag;   // zero when nothing returns
    logic [block_w-1:0] rsp_data;
    logic [tag_w-1:0]   tag_q  [$];
    logic [block_w-1:0] data_q [$];
    int                 due_q  [$];  // first cycle the data may return

    // merge a store of size bytes into a line at the byte offset
    function automatic logic [block_w-1:0] write_bytes(input logic [block_w-1:0] line,
                                                       input mem_req_t req);
        logic [block_w-1:0] res;
        int n;
        int off;
        int b;
        res = line;
        n   = 1 << req.size;
        off = req.addr[2:0];
        for (b = 0; b < 8; b++) begin
            if (b >= off && b < off + n) begin
                res[8*b +: 8] = req.data[8*(b-off) +: 8];
            end
        end
        return res;
    endfunction

    initial begin
        seed     = seed_init;
        rsp_tag  = '0;
        rsp_data = '0;
        for (k = 0; k < 256; k++) begin
            mem[k]    = {$random(seed), $random(seed)} ^ {8{k[7:0]}};  // line number mixed in
            shadow[k] = mem[k];
        end
    end

    // tag answer in the request cycle
    always_comb begin
        mem2proc.transaction_tag = (proc2mem.cmd != mem_none) ? next_tag : '0;
        mem2proc.data_tag        = rsp_tag;
        mem2proc.data            = rsp_data;
    end

    ////////////////////////////////////////
    // requests and returns
    ////////////////////////////////////////

    always @(posedge clock) begin
        if (reset) begin
            next_tag <= 4'd1;
            rsp_tag  <= '0;
            rsp_data <= '0;
            cyc = 0;
            tag_q.delete();
            data_q.delete();
            due_q.delete();
        end else begin
            if (proc2mem.cmd == mem_load) begin
                tag_q.push_back(next_tag);
                data_q.push_back(mem[proc2mem.addr[10:3]]);  // snapshot at request
                due_q.push_back(cyc + 1 + ($unsigned($random(seed)) % 6));
            end else if (proc2mem.cmd == mem_store) begin
                mem[proc2mem.addr[10:3]] = write_bytes(mem[proc2mem.addr[10:3]], proc2mem);
            end
            if (proc2mem.cmd != mem_none) begin
                next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;  // skip zero
            end
            // oldest due entry wins and the others slip a cycle
            found = 1'b0;
            pick  = 0;
            for (k = 0; k < tag_q.size(); k++) begin
                if (!found && due_q[k] <= cyc + 1) begin
                    found = 1'b1;
                    pick  = k;
                end
            end
            rsp_tag  <= found ? tag_q[pick] : '0;
            rsp_data <= found ? data_q[pick] : '0;
            if (found) begin
                tag_q.delete(pick);
                data_q.delete(pick);
                due_q.delete(pick);
            end
            cyc = cyc + 1;
        end
    end

endmodule

// File: test/mem_pipe_tb.sv
/*
  testbench for mem_pipe_top with the tagged memory model.
  stores only touch lines 224 to 255, far beyond what fetch reaches in one run,
  so fetched lines can be checked against the shadow copy.
*/

`timescale 1ns/1ps

module mem_pipe_tb import mem_pipe_pkg::*; ();

    localparam int unsigned rand_seed  = 32'he93a5364;
    localparam int          wait_limit = 300;  // cycles per wait
    localparam int          store_base = 224;  // first line stores may touch

    logic              clock;
    logic              reset;
    mem_op_t           op_in;
    mem_rsp_t          mem2proc;
    mem_req_t          proc2mem;
    logic              stall;
    commit_t           commit;
    fetch_t            fetched;
    logic [addr_w-1:0] pc;

    integer            seed;
    int                errors      = 0;
    int                checks      = 0;
    int                cycle       = 0;
    int                fetch_count = 0;
    logic              timed_out   = 1'b0;
    logic              stall_prev  = 1'b0;
    logic [addr_w-1:0] fetch_addr  = '0;  // next line fetch should deliver
    commit_t           exp_q   [$];       // expected commits in issue order
    int                due_q   [$];
    logic              exact_q [$];       // stores due exactly and loads no earlier
    commit_t           want;
    int                due;
    logic              exact;

    tb_clock clock_gen (
        .clock (clock),
        .reset (reset)
    );

    tb_mem_model #(.seed_init(rand_seed)) mem_model (
        .clock    (clock),
        .reset    (reset),
        .proc2mem (proc2mem),
        .mem2proc (mem2proc)
    );

    mem_pipe_top dut (
        .clock    (clock),
        .reset    (reset),
        .op_in    (op_in),
        .mem2proc (mem2proc),
        .proc2mem (proc2mem),
        .stall    (stall),
        .commit   (commit),
        .fetched  (fetched),
        .pc       (pc)
    );

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////
    // reference and helpers
    ////////////////////////////////////////

    // commit expected for op given the memory line it addresses
    function automatic commit_t expected_commit(input mem_op_t op,
                                                input logic [block_w-1:0] line);
        commit_t            c;
        logic [block_w-1:0] keep;
        keep   = (op.size == size_double) ? '1 : ((64'd1 << (8 << op.size)) - 64'd1);
        c.valid = 1'b1;
        c.cmd   = op.cmd;
        c.addr  = op.addr;
        if (op.cmd == mem_load) begin
            c.data = (line >> (8 * op.addr[2:0])) & keep;
        end else begin
            c.data = op.data & keep;
        end
        return c;
    endfunction

    // store bytes laid over the line at their byte offset
    function automatic logic [block_w-1:0] merge_store(input logic [block_w-1:0] line,
                                                       input mem_op_t op);
        logic [block_w-1:0] keep;
        int                 sh;
        keep = (op.size == size_double) ? '1 : ((64'd1 << (8 << op.size)) - 64'd1);
        sh   = 8 * op.addr[2:0];
        return (line & ~(keep << sh)) | ((op.data & keep) << sh);
    endfunction

    function automatic mem_op_t random_op(input mem_cmd_t cmd, input mem_size_t size,
                                          input int base_line, input int lines);
        mem_op_t op;
        int      line;
        int      offset;
        line     = base_line + ($unsigned($random(seed)) % lines);
        offset   = (($random(seed) & 7) >> size) << size;  // naturally aligned
        op.valid = 1'b1;
        op.cmd   = cmd;
        op.size  = size;
        op.addr  = addr_w'(line * line_bytes + offset);
        op.data  = {$random(seed), $random(seed)};
        return op;
    endfunction

    task automatic check_value(input string name, input logic [block_w-1:0] got,
                               input logic [block_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // call at 2 ns past an edge and returns likewise after the taking edge
    task automatic send_op(input mem_op_t op);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        if (timed_out) return;
        op_in = op;
        while (!taken && waited < wait_limit) begin
            @(negedge clock);
            taken = !stall;
            waited++;
        end
        if (!taken) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout: stall never dropped for the operation at %h", op.addr);
        end else begin
            @(posedge clock);
            #2;
            exp_q.push_back(expected_commit(op, mem_model.shadow[op.addr[10:3]]));
            due_q.push_back((op.cmd == mem_store) ? cycle + 1 : cycle + 2);
            exact_q.push_back(op.cmd == mem_store);
            if (op.cmd == mem_store) begin
                mem_model.shadow[op.addr[10:3]] =
                    merge_store(mem_model.shadow[op.addr[10:3]], op);
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < wait_limit) begin
            @(negedge clock);
            waited++;
        end
        if (exp_q.size() != 0) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout: %0d commits never arrived", exp_q.size());
        end
    endtask

    task automatic wait_fetches(input int n);
        int waited;
        int target;
        waited = 0;
        target = fetch_count + n;
        while (fetch_count < target && waited < wait_limit) begin
            @(negedge clock);
            waited++;
        end
        if (fetch_count < target) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout: fetch stopped after %0d lines", fetch_count);
        end
    endtask

    task automatic report_test(input int n, input string name, input int start);
        $display("test %0d %s: %0d errors", n, name, errors - start);
    endtask

    ////////////////////////////////////////
    // comparing process
    ////////////////////////////////////////

    always @(negedge clock) begin
        if (!reset) begin
            if (commit.valid && exp_q.size() == 0) begin
                errors++;
                $display("commit at address %h arrived with nothing outstanding", commit.addr);
            end else if (commit.valid) begin
                want  = exp_q.pop_front();
                due   = due_q.pop_front();
                exact = exact_q.pop_front();
                check_value("commit.cmd", commit.cmd, want.cmd);
                check_value("commit.addr", commit.addr, want.addr);
                check_value("commit.data", commit.data, want.data);
                if (exact ? (cycle != due) : (cycle < due)) begin
                    errors++;
                    $display("commit at address %h came in cycle %0d, due %0d",
                             commit.addr, cycle, due);
                end
            end
            if (fetched.valid) begin
                check_value("fetched.addr", fetched.addr, fetch_addr);
                check_value("fetched.data", fetched.data, mem_model.shadow[fetch_addr[10:3]]);
                fetch_addr = fetch_addr + line_bytes;
                check_value("pc", pc, fetch_addr);  // already stepped to the next line
                fetch_count++;
            end
            // a waiting load keeps the port quiet and fetch off it
            if (stall && stall_prev && proc2mem.cmd != mem_none) begin
                errors++;
                $display("memory request sent while a load was waiting at %0t", $time);
            end
            stall_prev = stall;
        end
    end

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    initial begin
        mem_op_t     ops [8];
        mem_op_t     op;
        logic [31:0] r;
        int          i;
        int          start;
        int          waited;
        seed   = rand_seed;
        op_in  = '0;
        waited = 0;

        start = errors;
        while (reset && waited < 40) begin
            @(negedge clock);
            waited++;
        end
        if (reset) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout: reset never released");
        end
        check_value("stall", stall, 0);
        check_value("commit.valid", commit.valid, 0);
        check_value("fetched.valid", fetched.valid, 0);
        check_value("pc", pc, 0);
        report_test(1, "reset state", start);

        start = errors;
        wait_fetches(8);
        report_test(2, "fetch alone", start);

        // two stores per size then a load of each
        start = errors;
        @(posedge clock);
        #2;
        for (i = 0; i < 8; i++) begin
            ops[i] = random_op(mem_store, mem_size_t'(i / 2), store_base, 32);
            send_op(ops[i]);
        end
        for (i = 0; i < 8; i++) begin
            op     = ops[i];
            op.cmd = mem_load;
            send_op(op);
        end
        op_in = '0;
        wait_drain();
        report_test(3, "stores and read back", start);

        start = errors;
        @(posedge clock);
        #2;
        for (i = 0; i < 16; i++) begin
            r = $random(seed);
            send_op(random_op(mem_load, mem_size_t'(r[1:0]), 0, 256));
        end
        op_in = '0;
        wait_drain();
        report_test(4, "loads", start);

        // back to back mix with the odd bubble so fetch gets the port
        start = errors;
        @(posedge clock);
        #2;
        for (i = 0; i < 40; i++) begin
            r = $random(seed);
            send_op(random_op(r[0] ? mem_load : mem_store, mem_size_t'(r[2:1]), store_base, 32));
            if (r[5:4] == 2'b00) begin
                op_in = '0;
                @(posedge clock);
                #2;
            end
        end
        op_in = '0;
        wait_drain();
        wait_fetches(2);
        report_test(5, "mixed traffic with fetch", start);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: sim.f
common/mem_pipe_pkg.sv
verilog/fetch_unit.sv
memory/mem_access.sv
memory/load_tracker.sv
verilog/pipe_regs.sv
verilog/mem_pipe_top.sv
test/tb_clock.sv
test/tb_mem_model.sv
test/mem_pipe_tb.sv

// File: Bender.yml
package:
  name: mem_pipe

sources:
  - common/mem_pipe_pkg.sv
  - verilog/fetch_unit.sv
  - memory/mem_access.sv
  - memory/load_tracker.sv
  - verilog/pipe_regs.sv
  - verilog/mem_pipe_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_mem_model.sv
      - test/mem_pipe_tb.sv
